/* compile.f */
common/timer_pkg.sv
prescaler/prescaler.sv
tima/tima_counter.sv
tima/overflow_fsm.sv
verilog/irq_flags.sv
verilog/timer_bus.sv
verilog/timer_top.sv
testbench/timer_props.sv
testbench/timer_tb.sv

/* Makefile */
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtimer_tb: compile.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module timer_tb -f compile.f

run: obj_dir/Vtimer_tb
	./obj_dir/Vtimer_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/timer_tb.sv */
`timescale 1ns/1ps

module timer_tb;

	logic                          clk;
	logic                          resetdiv;
	logic                          cpu_sel;
	logic                          cpu_wr;
	logic [timer_pkg::addr_w-1:0]  cpu_addr;
	logic [timer_pkg::data_w-1:0]  cpu_di;
	logic [timer_pkg::data_w-1:0]  cpu_do;
	logic [timer_pkg::n_src-1:0]   ext_req;
	logic                          irq_ack;
	logic                          irq;
	timer_pkg::irq_src_t           irq_src;

	integer     seed;
	int         errors;
	int         errors_before;
	int         tests_failed;
	logic [7:0] rd;
	logic [7:0] rd2;
	logic [7:0] val;
	logic [4:0] flags;
	logic [4:0] ie_set [6];
	int         period [4];
	int         steps [4];

	timer_top i_dut (
		.clk     (clk),      .resetdiv(resetdiv), .cpu_sel (cpu_sel),
		.cpu_wr  (cpu_wr),   .cpu_addr(cpu_addr), .cpu_di  (cpu_di),
		.cpu_do  (cpu_do),   .ext_req (ext_req),  .irq_ack (irq_ack),
		.irq     (irq),      .irq_src (irq_src)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// every task starts and ends 2 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		assert (actual === expected)
		else begin
			$display("Error at %0t ns: %s expected %02h, got %02h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	// write lands on the edge that ends this cycle
	task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
		cpu_sel  = 1'b1;
		cpu_wr   = 1'b1;
		cpu_addr = addr;
		cpu_di   = data;
		next_cycle();
		cpu_sel = 1'b0;
		cpu_wr  = 1'b0;
	endtask

	// combinational read sampled mid cycle
	task automatic read_reg(input logic [2:0] addr, output logic [7:0] data);
		cpu_sel  = 1'b1;
		cpu_wr   = 1'b0;
		cpu_addr = addr;
		#8;
		data = cpu_do;
		next_cycle();
		cpu_sel = 1'b0;
	endtask

	task automatic expect_reg(input logic [2:0] addr, input string name,
			input logic [7:0] expected);
		logic [7:0] data;
		read_reg(addr, data);
		check_byte(name, expected, data);
	endtask

	// returns one cycle after the matching read
	task automatic wait_reg(input logic [2:0] addr, input logic [7:0] value, input int limit);
		logic [7:0] data;
		int         n;
		n = 0;
		read_reg(addr, data);
		while (data !== value && n < limit) begin
			read_reg(addr, data);
			n++;
		end
		assert (data === value)
		else begin
			$display("%0t ns: timeout, register %0d never read %02h within %0d cycles",
				$time, addr, value, limit);
			errors++;
		end
	endtask

	task automatic pulse_ext(input logic [4:0] mask);
		ext_req = mask;
		next_cycle();
		ext_req = '0;
	endtask

	task automatic ack_irq();
		irq_ack = 1'b1;
		next_cycle();
		irq_ack = 1'b0;
	endtask

	// TIMA at FF with rate 16 so the first tick lands 16 edges after the return
	task automatic arm_overflow(input logic [7:0] modulo);
		write_reg(timer_pkg::REG_TAC, 8'h00);
		write_reg(timer_pkg::REG_TMA, modulo);
		write_reg(timer_pkg::REG_TIMA, 8'hff);
		write_reg(timer_pkg::REG_DIV, 8'h00);
		write_reg(timer_pkg::REG_TAC, 8'h05);
	endtask

	// lowest numbered pending source or 7 when none
	function automatic logic [2:0] lowest_source(input logic [4:0] pend);
		logic       found;
		logic [2:0] src;
		found = 1'b0;
		src   = 3'd7;
		for (int i = 0; i < 5; i++) begin
			if (pend[i] && !found) begin
				src   = 3'(i);
				found = 1'b1;
			end
		end
		return src;
	endfunction

	task automatic check_irq(input logic [4:0] pend);
		#8;
		check_byte("irq", {7'd0, |pend}, {7'd0, irq});
		check_byte("irq_src", {5'd0, lowest_source(pend)}, {5'd0, irq_src});
		next_cycle();
	endtask

	task automatic report(input string name);
		if (errors == errors_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
		errors_before = errors;
	endtask

	initial begin
		seed          = 32'h8b5d;
		errors        = 0;
		errors_before = 0;
		tests_failed  = 0;
		resetdiv      = 1'b1;
		cpu_sel       = 1'b0;
		cpu_wr        = 1'b0;
		cpu_addr      = '0;
		cpu_di        = '0;
		ext_req       = '0;
		irq_ack       = 1'b0;
		period        = '{1024, 16, 64, 256};
		steps         = '{2, 9, 5, 3};
		ie_set        = '{5'h1f, 5'h1b, 5'h14, 5'h18, 5'h05, 5'h00};
		repeat (10) @(posedge clk);
		#2;
		resetdiv = 1'b0;

		// unused bits read as ones
		expect_reg(timer_pkg::REG_DIV, "div", 8'h00);
		expect_reg(timer_pkg::REG_TIMA, "tima", 8'h00);
		expect_reg(timer_pkg::REG_TMA, "tma", 8'h00);
		expect_reg(timer_pkg::REG_TAC, "tac", 8'hf8);
		expect_reg(timer_pkg::REG_IF, "if", 8'he0);
		expect_reg(timer_pkg::REG_IE, "ie", 8'he0);
		expect_reg(3'd6, "unused addr 6", 8'hff);
		expect_reg(3'd7, "unused addr 7", 8'hff);
		check_irq(5'd0);
		report("reset values");

		// reads 768 cycles apart
		read_reg(timer_pkg::REG_DIV, rd);
		repeat (3 * 256 - 1) next_cycle();
		read_reg(timer_pkg::REG_DIV, rd2);
		check_byte("div step", rd + 8'd3, rd2);
		write_reg(timer_pkg::REG_DIV, 8'h5a);
		for (int i = 0; i < 256; i++) begin
			expect_reg(timer_pkg::REG_DIV, "div after clear", 8'h00);
		end
		expect_reg(timer_pkg::REG_DIV, "div after 256 cycles", 8'h01);
		report("div");

		// div clear aligns the first tick one period after enable
		for (int r = 0; r < 4; r++) begin
			val = 8'($random(seed)) & 8'h7f;
			write_reg(timer_pkg::REG_TAC, 8'h00);
			write_reg(timer_pkg::REG_TIMA, val);
			write_reg(timer_pkg::REG_DIV, 8'h00);
			write_reg(timer_pkg::REG_TAC, 8'h04 | 8'(r));
			repeat (steps[r] * period[r]) next_cycle();
			expect_reg(timer_pkg::REG_TIMA, "tima count", val + 8'(steps[r]));
			expect_reg(timer_pkg::REG_TAC, "tac", 8'hfc | 8'(r));
			write_reg(timer_pkg::REG_TAC, 8'(r));
			repeat (4 * period[r]) next_cycle();
			expect_reg(timer_pkg::REG_TIMA, "tima held", val + 8'(steps[r]));
		end
		report("rates");

		write_reg(timer_pkg::REG_IE, 8'h00);
		write_reg(timer_pkg::REG_IF, 8'h00);
		val = 8'($random(seed));
		arm_overflow(val);
		wait_reg(timer_pkg::REG_TIMA, 8'h00, 40);
		expect_reg(timer_pkg::REG_TIMA, "tima second zero cycle", 8'h00);
		expect_reg(timer_pkg::REG_TIMA, "tima after reload", val);
		write_reg(timer_pkg::REG_TAC, 8'h00);
		expect_reg(timer_pkg::REG_IF, "if after overflow", 8'he4);
		report("overflow");

		// write lands in the cycle right after the wrap
		write_reg(timer_pkg::REG_IF, 8'h00);
		arm_overflow(8'h33);
		repeat (16) next_cycle();
		val = 8'($random(seed)) & 8'h7f;
		cpu_sel  = 1'b1;
		cpu_wr   = 1'b1;
		cpu_addr = timer_pkg::REG_TIMA;
		cpu_di   = val;
		#8;
		check_byte("tima in overflow cycle", 8'h00, cpu_do);
		next_cycle();
		cpu_sel = 1'b0;
		cpu_wr  = 1'b0;
		for (int i = 0; i < 3; i++) begin
			expect_reg(timer_pkg::REG_TIMA, "tima after cancel", val);
		end
		write_reg(timer_pkg::REG_TAC, 8'h00);
		expect_reg(timer_pkg::REG_IF, "if after cancel", 8'he0);
		report("cancel");

		// ext bit 2 is ignored and the timer fills that slot
		for (int i = 0; i < 6; i++) begin
			write_reg(timer_pkg::REG_IE, 8'h00);
			write_reg(timer_pkg::REG_IF, 8'h00);
			flags = 5'($random(seed));
			pulse_ext(flags);
			flags = flags & 5'b11011;
			if (i % 2 == 0) begin
				arm_overflow(8'h80);
				wait_reg(timer_pkg::REG_TIMA, 8'h00, 40);
				next_cycle();
				next_cycle();
				write_reg(timer_pkg::REG_TAC, 8'h00);
				flags[2] = 1'b1;
			end
			expect_reg(timer_pkg::REG_IF, "if before ack", {3'b111, flags});
			write_reg(timer_pkg::REG_IE, {3'b000, ie_set[i]});
			for (int n = 0; n < 6 && (flags & ie_set[i]) != 5'd0; n++) begin
				check_irq(flags & ie_set[i]);
				flags[lowest_source(flags & ie_set[i])] = 1'b0;
				ack_irq();
			end
			check_irq(flags & ie_set[i]);
			expect_reg(timer_pkg::REG_IF, "if after ack", {3'b111, flags});
		end
		report("priority and ack");

		$display("tests 6, failed %0d, check errors %0d, assertion failures %0d",
			tests_failed, errors, i_dut.i_props.fail_count);
		if (errors == 0 && tests_failed == 0 && i_dut.i_props.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* testbench/timer_props.sv */
`timescale 1ns/1ps

module timer_props (
	input logic                          clk,
	input logic                          resetdiv,
	input logic                          carry,
	input logic                          tima_wr,
	input logic                          tma_wr,
	input logic [timer_pkg::data_w-1:0]  wr_data,
	input logic [timer_pkg::data_w-1:0]  tima,
	input logic [timer_pkg::data_w-1:0]  tma,
	input logic                          reload,
	input logic                          timer_req,
	input logic                          if_wr,
	input logic [timer_pkg::n_src-1:0]   if_val,
	input logic [timer_pkg::n_src-1:0]   ie_val,
	input logic [timer_pkg::n_src-1:0]   ext_req,
	input logic                          irq_ack,
	input logic                          irq,
	input timer_pkg::irq_src_t           irq_src
);

	int unsigned fail_count = 0;

	// ack seen last cycle with nothing else touching IF
	logic                        ack_seen;
	logic [timer_pkg::n_src-1:0] ack_bit;
	logic [timer_pkg::n_src-1:0] if_before;

	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			ack_seen  <= 1'b0;
			ack_bit   <= '0;
			if_before <= '0;
		end else begin
			ack_seen  <= irq_ack && irq && !if_wr && (ext_req == '0) && !timer_req;
			ack_bit   <= 5'b00001 << irq_src;
			if_before <= if_val;
		end
	end

	// TIMA sits at 00 for two cycles after the wrap
	a_zero: assert property (@(posedge clk) disable iff (resetdiv)
		$past(carry) || ($past(carry, 2) && !$past(tima_wr)) |-> tima == 8'h00)
		else begin
			fail_count++;
			$error("TIMA not 00 after wrap");
		end

	// reload and timer flag on the second edge after the wrap
	a_reload: assert property (@(posedge clk) disable iff (resetdiv)
		$past(carry, 3) && !$past(tima_wr, 2) && !$past(tima_wr) && !$past(tma_wr)
		|-> (tima == tma) && if_val[timer_pkg::SRC_TIMER])
		else begin
			fail_count++;
			$error("TIMA reload or timer flag missing");
		end

	// cpu write in the delay cycle drops reload and request
	a_cancel: assert property (@(posedge clk) disable iff (resetdiv)
		$past(carry, 2) && $past(tima_wr) |-> !reload && !timer_req && tima == $past(wr_data))
		else begin
			fail_count++;
			$error("TIMA write did not cancel reload");
		end

	a_ie_zero: assert property (@(posedge clk) disable iff (resetdiv)
		ie_val == '0 |-> !irq)
		else begin
			fail_count++;
			$error("irq high with IE clear");
		end

	a_no_src: assert property (@(posedge clk) disable iff (resetdiv)
		!irq |-> irq_src == timer_pkg::SRC_NONE)
		else begin
			fail_count++;
			$error("irq_src set without irq");
		end

	a_ack: assert property (@(posedge clk) disable iff (resetdiv)
		ack_seen |-> if_val == (if_before & ~ack_bit))
		else begin
			fail_count++;
			$error("ack did not clear exactly one flag");
		end

endmodule

bind timer_top timer_props i_props (
	.clk      (clk),       .resetdiv (resetdiv),  .carry    (carry),
	.tima_wr  (tima_wr),   .tma_wr   (tma_wr),    .wr_data  (wr_data),
	.tima     (tima),      .tma      (tma),       .reload   (reload),
	.timer_req(timer_req), .if_wr    (if_wr),     .if_val   (if_val),
	.ie_val   (ie_val),    .ext_req  (ext_req),   .irq_ack  (irq_ack),
	.irq      (irq),       .irq_src  (irq_src)
);

/* verilog/timer_top.sv */
`timescale 1ns/1ps

module timer_top (
	input  logic                          clk,
	input  logic                          resetdiv,
	input  logic                          cpu_sel,
	input  logic                          cpu_wr,
	input  logic [timer_pkg::addr_w-1:0]  cpu_addr,
	input  logic [timer_pkg::data_w-1:0]  cpu_di,
	output logic [timer_pkg::data_w-1:0]  cpu_do,
	input  logic [timer_pkg::n_src-1:0]   ext_req,
	input  logic                          irq_ack,
	output logic                          irq,
	output timer_pkg::irq_src_t           irq_src
);

	// bus strobes
	logic                          div_clr;
	logic                          tima_wr;
	logic                          tma_wr;
	logic                          tac_wr;
	logic                          if_wr;
	logic                          ie_wr;
	logic [timer_pkg::data_w-1:0]  wr_data;
	// register views for readback
	logic [timer_pkg::data_w-1:0]  div;
	logic [timer_pkg::data_w-1:0]  tima;
	logic [timer_pkg::data_w-1:0]  tma;
	logic [timer_pkg::tac_w-1:0]   tac;
	logic [timer_pkg::n_src-1:0]   if_val;
	logic [timer_pkg::n_src-1:0]   ie_val;
	// timer datapath
	logic                          tac_en;
	timer_pkg::rate_t              tac_rate;
	logic                          tick;
	logic                          carry;
	logic                          reload;
	logic                          timer_req;

	timer_bus i_bus (
		.cpu_sel (cpu_sel),  .cpu_wr (cpu_wr),   .cpu_addr(cpu_addr),
		.cpu_di  (cpu_di),   .cpu_do (cpu_do),   .div_clr (div_clr),
		.tima_wr (tima_wr),  .tma_wr (tma_wr),   .tac_wr  (tac_wr),
		.if_wr   (if_wr),    .ie_wr  (ie_wr),    .wr_data (wr_data),
		.div     (div),      .tima   (tima),     .tma     (tma),
		.tac     (tac),      .if_val (if_val),   .ie_val  (ie_val)
	);

	prescaler i_prescaler (
		.clk     (clk),      .resetdiv(resetdiv), .div_clr (div_clr),
		.tac_en  (tac_en),   .tac_rate(tac_rate), .tick    (tick),
		.div     (div)
	);

	tima_counter i_tima (
		.clk     (clk),      .resetdiv(resetdiv), .tick    (tick),
		.reload  (reload),   .tima_wr (tima_wr),  .tma_wr  (tma_wr),
		.tac_wr  (tac_wr),   .wr_data (wr_data),  .tac_en  (tac_en),
		.tac_rate(tac_rate), .carry   (carry),    .tima    (tima),
		.tma     (tma),      .tac     (tac)
	);

	overflow_fsm i_ovf (
		.clk     (clk),      .resetdiv(resetdiv), .carry   (carry),
		.tima_wr (tima_wr),  .reload  (reload),   .timer_req(timer_req)
	);

	irq_flags i_irq (
		.clk     (clk),      .resetdiv(resetdiv), .timer_req(timer_req),
		.ext_req (ext_req),  .if_wr   (if_wr),    .ie_wr    (ie_wr),
		.wr_data (wr_data),  .irq_ack (irq_ack),  .irq      (irq),
		.irq_src (irq_src),  .if_val  (if_val),   .ie_val   (ie_val)
	);

endmodule

/* verilog/timer_bus.sv */
`timescale 1ns/1ps

module timer_bus (
	input  logic                          cpu_sel,
	input  logic                          cpu_wr,
	input  logic [timer_pkg::addr_w-1:0]  cpu_addr,
	input  logic [timer_pkg::data_w-1:0]  cpu_di,
	output logic [timer_pkg::data_w-1:0]  cpu_do,
	output logic                          div_clr,
	output logic                          tima_wr,
	output logic                          tma_wr,
	output logic                          tac_wr,
	output logic                          if_wr,
	output logic                          ie_wr,
	output logic [timer_pkg::data_w-1:0]  wr_data,
	input  logic [timer_pkg::data_w-1:0]  div,
	input  logic [timer_pkg::data_w-1:0]  tima,
	input  logic [timer_pkg::data_w-1:0]  tma,
	input  logic [timer_pkg::tac_w-1:0]   tac,
	input  logic [timer_pkg::n_src-1:0]   if_val,
	input  logic [timer_pkg::n_src-1:0]   ie_val
);

	timer_pkg::reg_addr_t addr;
	logic                 wr_en;

	assign addr    = timer_pkg::reg_addr_t'(cpu_addr);
	assign wr_en   = cpu_sel && cpu_wr;
	// write data goes to every register, the strobe picks one
	assign wr_data = cpu_di;

	// one strobe per register, single cycle
	always_comb begin
		div_clr = 1'b0;
		tima_wr = 1'b0;
		tma_wr  = 1'b0;
		tac_wr  = 1'b0;
		if_wr   = 1'b0;
		ie_wr   = 1'b0;
		if (wr_en) begin
			case (addr)
				timer_pkg::REG_DIV:  div_clr = 1'b1;
				timer_pkg::REG_TIMA: tima_wr = 1'b1;
				timer_pkg::REG_TMA:  tma_wr  = 1'b1;
				timer_pkg::REG_TAC:  tac_wr  = 1'b1;
				timer_pkg::REG_IF:   if_wr   = 1'b1;
				timer_pkg::REG_IE:   ie_wr   = 1'b1;
				default: ;
			endcase
		end
	end

	// read path, no storage behind the upper bits so they read as ones
	always_comb begin
		case (addr)
			timer_pkg::REG_DIV:  cpu_do = div;
			timer_pkg::REG_TIMA: cpu_do = tima;
			timer_pkg::REG_TMA:  cpu_do = tma;
			timer_pkg::REG_TAC:
				cpu_do = {timer_pkg::unused_fill[timer_pkg::data_w-1:timer_pkg::tac_w], tac};
			timer_pkg::REG_IF:
				cpu_do = {timer_pkg::unused_fill[timer_pkg::data_w-1:timer_pkg::n_src], if_val};
			timer_pkg::REG_IE:
				cpu_do = {timer_pkg::unused_fill[timer_pkg::data_w-1:timer_pkg::n_src], ie_val};
			default: cpu_do = timer_pkg::unused_fill;
		endcase
	end

endmodule

/* verilog/irq_flags.sv */
`timescale 1ns/1ps

module irq_flags (
	input  logic                          clk,
	input  logic                          resetdiv,
	input  logic                          timer_req,
	input  logic [timer_pkg::n_src-1:0]   ext_req,
	input  logic                          if_wr,
	input  logic                          ie_wr,
	input  logic [timer_pkg::data_w-1:0]  wr_data,
	input  logic                          irq_ack,
	output logic                          irq,
	output timer_pkg::irq_src_t           irq_src,
	output logic [timer_pkg::n_src-1:0]   if_val,
	output logic [timer_pkg::n_src-1:0]   ie_val
);

	logic [timer_pkg::n_src-1:0] set_mask;
	logic [timer_pkg::n_src-1:0] ack_mask;
	logic [timer_pkg::n_src-1:0] pending;

	// timer slot comes from the overflow fsm, ext_req[2] dropped
	assign set_mask = {ext_req[4:3], timer_req, ext_req[1:0]};

	assign pending = if_val & ie_val;
	assign irq     = |pending;

	// lowest pending and enabled source wins
	always_comb begin
		irq_src = timer_pkg::SRC_NONE;
		for (int i = timer_pkg::n_src - 1; i >= 0; i--) begin
			if (pending[i]) begin
				irq_src = timer_pkg::irq_src_t'(i);
			end
		end
	end

	// ack clears whatever irq_src currently names
	always_comb begin
		ack_mask = '0;
		if (irq_ack && (irq_src != timer_pkg::SRC_NONE)) begin
			ack_mask[irq_src] = 1'b1;
		end
	end

	// cpu write replaces, ack clears, new requests set last so they win
	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			if_val <= timer_pkg::if_rst;
		end else if (if_wr) begin
			if_val <= wr_data[timer_pkg::n_src-1:0] | set_mask;
		end else begin
			if_val <= (if_val & ~ack_mask) | set_mask;
		end
	end

	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			ie_val <= timer_pkg::ie_rst;
		end else if (ie_wr) begin
			ie_val <= wr_data[timer_pkg::n_src-1:0];
		end
	end

endmodule

/* tima/overflow_fsm.sv */
`timescale 1ns/1ps

module overflow_fsm (
	input  logic clk,
	input  logic resetdiv,
	input  logic carry,
	input  logic tima_wr,
	output logic reload,
	output logic timer_req
);

	timer_pkg::tima_state_t state;
	timer_pkg::tima_state_t state_next;

	// ST_COUNT: normal counting
	// ST_OVERFLOW: TIMA sits at 00, cpu may still cancel
	// ST_RELOAD: TMA copy and irq request on the closing edge
	always_comb begin
		state_next = state;
		case (state)
			timer_pkg::ST_COUNT: begin
				if (carry) begin
					state_next = timer_pkg::ST_OVERFLOW;
				end
			end
			timer_pkg::ST_OVERFLOW: begin
				// write to TIMA in the delay cycle drops reload and irq
				if (tima_wr) begin
					state_next = timer_pkg::ST_COUNT;
				end else begin
					state_next = timer_pkg::ST_RELOAD;
				end
			end
			timer_pkg::ST_RELOAD: begin
				if (carry) begin
					state_next = timer_pkg::ST_OVERFLOW;
				end else begin
					state_next = timer_pkg::ST_COUNT;
				end
			end
			default: state_next = timer_pkg::ST_COUNT;
		endcase
	end

	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			state     <= timer_pkg::ST_COUNT;
			reload    <= 1'b0;
			timer_req <= 1'b0;
		end else begin
			state <= state_next;
			// registered, so both are high exactly while in ST_RELOAD
			reload    <= (state_next == timer_pkg::ST_RELOAD);
			timer_req <= (state_next == timer_pkg::ST_RELOAD);
		end
	end

endmodule

/* tima/tima_counter.sv */
`timescale 1ns/1ps

module tima_counter (
	input  logic                            clk,
	input  logic                            resetdiv,
	input  logic                            tick,
	input  logic                            reload,
	input  logic                            tima_wr,
	input  logic                            tma_wr,
	input  logic                            tac_wr,
	input  logic [timer_pkg::data_w-1:0]    wr_data,
	output logic                            tac_en,
	output timer_pkg::rate_t                tac_rate,
	output logic                            carry,
	output logic [timer_pkg::data_w-1:0]    tima,
	output logic [timer_pkg::data_w-1:0]    tma,
	output logic [timer_pkg::tac_w-1:0]     tac
);

	// TIMA at FF and about to wrap on this tick
	// a cpu write in the same cycle swallows the wrap
	assign carry = tick && (tima == '1) && !tima_wr;

	// priority: cpu write, then reload, then count
	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			tima <= timer_pkg::tima_rst;
		end else if (tima_wr) begin
			tima <= wr_data;
		end else if (reload) begin
			tima <= tma;
		end else if (tick) begin
			// FF wraps to 00 here, overflow fsm handles the rest
			tima <= tima + 1'b1;
		end
	end

	// modulo register
	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			tma <= timer_pkg::tma_rst;
		end else if (tma_wr) begin
			tma <= wr_data;
		end
	end

	// only three bits of TAC are stored
	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			tac <= timer_pkg::tac_rst;
		end else if (tac_wr) begin
			tac <= wr_data[timer_pkg::tac_w-1:0];
		end
	end

	// bit 2 enable, bits 1:0 rate code
	assign tac_en   = tac[2];
	assign tac_rate = timer_pkg::rate_t'(tac[1:0]);

endmodule

/* prescaler/prescaler.sv */
`timescale 1ns/1ps

module prescaler (
	input  logic                             clk,
	input  logic                             resetdiv,
	input  logic                             div_clr,
	input  logic                             tac_en,
	input  timer_pkg::rate_t                 tac_rate,
	output logic                             tick,
	output logic [timer_pkg::data_w-1:0]     div
);

	// free running system counter
	logic [timer_pkg::presc_w-1:0] count;
	// low bits that must be zero for a tick
	logic [timer_pkg::presc_w-1:0] rate_mask;

	// runs every clock, cpu write to DIV clears all 16 bits
	always_ff @(posedge clk or posedge resetdiv) begin
		if (resetdiv) begin
			count <= timer_pkg::presc_rst;
		end else if (div_clr) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// DIV is the upper byte, one step per 256 clocks
	assign div = count[timer_pkg::presc_w-1 -: timer_pkg::data_w];

	// rate code to mask
	always_comb begin
		case (tac_rate)
			timer_pkg::RATE_1024: rate_mask = timer_pkg::mask_1024;
			timer_pkg::RATE_16:   rate_mask = timer_pkg::mask_16;
			timer_pkg::RATE_64:   rate_mask = timer_pkg::mask_64;
			timer_pkg::RATE_256:  rate_mask = timer_pkg::mask_256;
			default:              rate_mask = timer_pkg::mask_1024;
		endcase
	end

	// enable only tested here
	// tick lasts one clock since the count moves every clock
	assign tick = tac_en && ((count & rate_mask) == '0);

endmodule

/* common/timer_pkg.sv */
package timer_pkg;

	// bus and counter widths
	localparam int data_w  = 8;
	localparam int addr_w  = 3;
	localparam int presc_w = 16;
	localparam int tac_w   = 3;
	localparam int n_src   = 5;

	// read value for bits that have no storage behind them
	localparam logic [data_w-1:0] unused_fill = '1;

	// reset values of the cpu visible registers
	localparam logic [data_w-1:0]  tima_rst = '0;
	localparam logic [data_w-1:0]  tma_rst  = '0;
	localparam logic [tac_w-1:0]   tac_rst  = '0;
	localparam logic [n_src-1:0]   if_rst   = '0;
	localparam logic [n_src-1:0]   ie_rst   = '0;
	localparam logic [presc_w-1:0] presc_rst = '0;

	// prescaler low-bit masks, one per tac rate code
	localparam logic [presc_w-1:0] mask_1024 = 16'h03ff;
	localparam logic [presc_w-1:0] mask_16   = 16'h000f;
	localparam logic [presc_w-1:0] mask_64   = 16'h003f;
	localparam logic [presc_w-1:0] mask_256  = 16'h00ff;

	// register map, 6 and 7 read as all ones
	typedef enum logic [addr_w-1:0] {
		REG_DIV  = 3'd0,
		REG_TIMA = 3'd1,
		REG_TMA  = 3'd2,
		REG_TAC  = 3'd3,
		REG_IF   = 3'd4,
		REG_IE   = 3'd5
	} reg_addr_t;

	// tac[1:0] rate codes
	typedef enum logic [1:0] {
		RATE_1024 = 2'd0,
		RATE_16   = 2'd1,
		RATE_64   = 2'd2,
		RATE_256  = 2'd3
	} rate_t;

	typedef enum logic [1:0] {
		ST_COUNT    = 2'd0,
		ST_OVERFLOW = 2'd1,
		ST_RELOAD   = 2'd2
	} tima_state_t;

	// lower number wins
	typedef enum logic [2:0] {
		SRC_VBLANK = 3'd0,
		SRC_LCD    = 3'd1,
		SRC_TIMER  = 3'd2,
		SRC_SERIAL = 3'd3,
		SRC_JOYPAD = 3'd4,
		SRC_NONE   = 3'd7
	} irq_src_t;

endpackage
